/* compile.f */
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/memory_access_stage.sv
logic/riscv_core.sv
sim/riscv_core_properties.sv
sim/riscv_core_tb.sv

/* sim/riscv_core_tb.sv */
`timescale 1ns/1ps

module riscv_core_tb;

    localparam int MAX_WORDS    = 80;   // all programs together
    localparam int NUM_TESTS    = 5;
    localparam int LIMIT_CYCLES = 3 * MAX_WORDS + 40 * NUM_TESTS;
    localparam core_pkg::word_t LOOP_WORD = 32'h0000_006f;  // jal x0,0

    logic                clk_cpu;
    logic                rstn;
    logic                run;
    logic                imem_we;
    logic [7:0]          imem_addr;
    core_pkg::word_t     imem_wdata;
    logic                wb_en;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t     wb_data;
    logic                st_en;
    core_pkg::addr_t     st_addr;
    core_pkg::word_t     st_data;

    int                  errors;
    int                  checks;
    string               cur_test;
    logic [31:0]         lfsr_state;
    core_pkg::word_t     prog [$];
    core_pkg::reg_addr_t exp_rd [$];
    core_pkg::word_t     exp_val [$];
    core_pkg::addr_t     exp_sa [$];
    core_pkg::word_t     exp_sd [$];
    core_pkg::reg_addr_t act_rd [$];
    core_pkg::word_t     act_val [$];
    core_pkg::addr_t     act_sa [$];
    core_pkg::word_t     act_sd [$];

    riscv_core #(
        .IMEM_AW (8),
        .DMEM_AW (8)
    ) riscv_core_inst (
        .clk_cpu    (clk_cpu),
        .rstn       (rstn),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .st_en      (st_en),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    always #4 clk_cpu = ~clk_cpu;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic core_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic sub, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, core_pkg::OP_REG};
    endfunction

    function automatic core_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::OP_BRANCH};
    endfunction

    function automatic core_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OP_JAL};
    endfunction

    task automatic check_word(input string what, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_reg(input core_pkg::reg_addr_t exp, input core_pkg::reg_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s rd: expected x%0d actual x%0d", cur_test, exp, act);
        end
    endtask

    task automatic check_store(input core_pkg::addr_t ea, input core_pkg::word_t ed,
                               input core_pkg::addr_t aa, input core_pkg::word_t ad);
        checks++;
        if (ea !== aa || ed !== ad) begin
            errors++;
            $display("Mismatch %s store: expected %h <= %h actual %h <= %h",
                     cur_test, ea, ed, aa, ad);
        end
    endtask

    // collects results, nothing may come out while held
    always @(negedge clk_cpu) begin
        if (!rstn || !run) begin
            if (wb_en || st_en) begin
                errors++;
                $display("%s: write-back or store seen while in reset or halted", cur_test);
            end
        end else begin
            if (wb_en) begin
                act_rd.push_back(wb_rd);
                act_val.push_back(wb_data);
            end
            if (st_en) begin
                act_sa.push_back(st_addr);
                act_sd.push_back(st_data);
            end
        end
    end

    // in-order isa model, stops at the self loop
    task automatic run_model();
        core_pkg::word_t mregs [32];
        core_pkg::word_t mdmem [core_pkg::addr_t];
        core_pkg::addr_t pc;
        core_pkg::addr_t ea;
        core_pkg::word_t ins;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t res;
        core_pkg::addr_t next_pc;
        logic            wr;
        logic            tk;
        int              steps;
        foreach (mregs[i]) mregs[i] = '0;
        pc = '0;
        for (steps = 0; steps < 256; steps++) begin
            ins = prog[pc[31:2]];
            if (ins == LOOP_WORD) break;
            a       = mregs[ins[19:15]];
            b       = mregs[ins[24:20]];
            wr      = 1'b1;
            res     = '0;
            next_pc = pc + 4;
            case (ins[6:0])
                core_pkg::OP_IMM:
                    res = (ins[14:12] == 3'b001) ? (a << ins[24:20])
                                                 : a + {{20{ins[31]}}, ins[31:20]};
                core_pkg::OP_REG:   res = ins[30] ? a - b : a + b;
                core_pkg::OP_LOAD: begin
                    ea  = a + {{20{ins[31]}}, ins[31:20]};
                    res = mdmem.exists(ea) ? mdmem[ea] : '0;
                end
                core_pkg::OP_STORE: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mdmem[ea] = b;
                    exp_sa.push_back(ea);
                    exp_sd.push_back(b);
                    wr = 1'b0;
                end
                core_pkg::OP_BRANCH: begin
                    case (ins[14:12])
                        3'b000:  tk = (a == b);
                        3'b001:  tk = (a != b);
                        3'b100:  tk = ($signed(a) < $signed(b));
                        default: tk = ($signed(a) >= $signed(b));
                    endcase
                    if (tk) next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    wr = 1'b0;
                end
                core_pkg::OP_JAL: begin
                    res     = pc + 4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                core_pkg::OP_AUIPC: res = pc + {ins[31:12], 12'h000};
                default:            wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                mregs[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_val.push_back(res);
            end
            pc = next_pc;
        end
        if (steps == 256) begin
            errors++;
            $display("%s: reference model never reached the end loop", cur_test);
        end
    endtask

    task automatic run_program(input string name);
        int limit;
        cur_test = name;
        prog.push_back(LOOP_WORD);
        exp_rd.delete();
        exp_val.delete();
        exp_sa.delete();
        exp_sd.delete();
        act_rd.delete();
        act_val.delete();
        act_sa.delete();
        act_sd.delete();
        rstn = 1'b0;                       // core is held for the whole load
        repeat (8) @(posedge clk_cpu);
        #1 rstn = 1'b1;
        foreach (prog[i]) begin
            imem_we    = 1'b1;
            imem_addr  = i[7:0];
            imem_wdata = prog[i];
            @(posedge clk_cpu);
            #1;
        end
        imem_we = 1'b0;
        run_model();
        run = 1'b1;
        limit = 2 * prog.size() + 16;
        for (int c = 0; c < limit; c++) begin
            if (act_rd.size() >= exp_rd.size() && act_sa.size() >= exp_sa.size()) break;
            @(posedge clk_cpu);
        end
        repeat (6) @(posedge clk_cpu);     // room for any extra events
        #1 run = 1'b0;
        if (act_rd.size() != exp_rd.size()) begin
            errors++;
            $display("%s: expected %0d write-backs, saw %0d", name, exp_rd.size(), act_rd.size());
        end
        if (act_sa.size() != exp_sa.size()) begin
            errors++;
            $display("%s: expected %0d stores, saw %0d", name, exp_sa.size(), act_sa.size());
        end
        for (int i = 0; i < exp_rd.size() && i < act_rd.size(); i++) begin
            check_reg(exp_rd[i], act_rd[i]);
            check_word("wb_data", exp_val[i], act_val[i]);
        end
        for (int i = 0; i < exp_sa.size() && i < act_sa.size(); i++) begin
            check_store(exp_sa[i], exp_sd[i], act_sa[i], act_sd[i]);
        end
        prog.delete();
    endtask

    task automatic add_nops(input int n);
        repeat (n) prog.push_back(core_pkg::NOP_WORD);
    endtask

    task automatic test_alu();
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'hffb, 5'd0, 3'b000, 5'd2, core_pkg::OP_IMM));   // -5
        add_nops(2);
        prog.push_back(enc_r(1'b0, 5'd2, 5'd1, 5'd3));
        prog.push_back(enc_r(1'b1, 5'd2, 5'd1, 5'd4));
        prog.push_back(enc_i({7'b0, 5'(rand_bits(5))}, 5'd1, 3'b001, 5'd5, core_pkg::OP_IMM));
        prog.push_back({20'(rand_bits(20)), 5'd6, core_pkg::OP_AUIPC});
        prog.push_back(enc_i(12'h800, 5'd2, 3'b000, 5'd7, core_pkg::OP_IMM));   // most negative
        run_program("alu");
    endtask

    task automatic test_memory();
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'h040, 5'd0, 3'b000, 5'd2, core_pkg::OP_IMM));
        add_nops(2);
        prog.push_back({7'b0, 5'd1, 5'd2, 3'b010, 5'd8, core_pkg::OP_STORE});     // sw x1,8(x2)
        prog.push_back(enc_i(12'h008, 5'd2, 3'b010, 5'd3, core_pkg::OP_LOAD));
        add_nops(2);
        prog.push_back(enc_i(12'h001, 5'd3, 3'b000, 5'd4, core_pkg::OP_IMM));
        run_program("memory");
    endtask

    // branch, two wrong-path writes, then the target
    task automatic branch_block(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back(enc_b(13'd12, rs2, rs1, f3));
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd10, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd11, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd12, core_pkg::OP_IMM));
    endtask

    task automatic test_branches();
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, core_pkg::OP_IMM));
        add_nops(2);
        prog.push_back(enc_i(12'h001, 5'd1, 3'b000, 5'd2, core_pkg::OP_IMM));    // x2 = x1 + 1
        prog.push_back(enc_i(12'h000, 5'd1, 3'b000, 5'd3, core_pkg::OP_IMM));    // x3 = x1
        add_nops(2);
        branch_block(3'b000, 5'd1, 5'd3);
        branch_block(3'b000, 5'd1, 5'd2);
        branch_block(3'b001, 5'd1, 5'd2);
        branch_block(3'b001, 5'd1, 5'd3);
        branch_block(3'b100, 5'd1, 5'd2);
        branch_block(3'b100, 5'd2, 5'd1);
        branch_block(3'b101, 5'd2, 5'd1);
        branch_block(3'b101, 5'd1, 5'd2);
        run_program("branches");
    endtask

    task automatic test_jal();
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd2, core_pkg::OP_IMM));
        prog.push_back(enc_j(21'd12, 5'd1));
        prog.push_back(enc_i(12'h001, 5'd0, 3'b000, 5'd5, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'h002, 5'd0, 3'b000, 5'd6, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'h003, 5'd2, 3'b000, 5'd7, core_pkg::OP_IMM));    // target
        add_nops(2);
        prog.push_back(enc_r(1'b0, 5'd0, 5'd1, 5'd8));
        run_program("jal");
    endtask

    task automatic test_x0();
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, core_pkg::OP_IMM));
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd0, core_pkg::OP_IMM));
        add_nops(2);
        prog.push_back(enc_r(1'b0, 5'd1, 5'd1, 5'd0));
        add_nops(2);
        prog.push_back(enc_r(1'b0, 5'd0, 5'd0, 5'd3));                           // reads x0
        prog.push_back(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd4, core_pkg::OP_IMM));
        run_program("x0");
    endtask

    initial begin
        #(LIMIT_CYCLES * 8);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk_cpu    = 1'b0;
        rstn       = 1'b1;                 // each test pulls reset itself
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        errors     = 0;
        checks     = 0;
        cur_test   = "reset";
        lfsr_state = 32'h1e07_1028;
        @(posedge clk_cpu);
        #1;
        test_alu();
        test_memory();
        test_branches();
        test_jal();
        test_x0();
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 riscv_core_inst.riscv_core_properties_inst.fail_count);
        if (errors == 0 && riscv_core_inst.riscv_core_properties_inst.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim/riscv_core_properties.sv */
`timescale 1ns/1ps

module riscv_core_properties (
    input logic                clk_cpu,
    input logic                rstn,
    input logic                wb_en,
    input logic                st_en,
    input core_pkg::reg_addr_t wb_rd,
    input core_pkg::word_t     wb_data
);

    int fail_count = 0;   // failed assertions so far

    // outputs stay quiet in reset
    quiet_in_reset: assert property (@(posedge clk_cpu) !rstn |-> (!wb_en && !st_en))
        else begin
            fail_count++;
            $error("write-back or store active during reset");
        end

    no_x0_write: assert property (@(posedge clk_cpu) disable iff (!rstn) wb_en |-> (wb_rd != '0))
        else begin
            fail_count++;
            $error("write-back to x0");
        end

    wb_data_known: assert property (@(posedge clk_cpu) disable iff (!rstn)
        wb_en |-> !$isunknown(wb_data))
        else begin
            fail_count++;
            $error("write-back data has unknown bits");
        end

endmodule

bind riscv_core riscv_core_properties riscv_core_properties_inst (
    .clk_cpu (clk_cpu),
    .rstn    (rstn),
    .wb_en   (wb_en),
    .st_en   (st_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
);

/* logic/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  logic                run,
    input  logic                imem_we,
    input  logic [IMEM_AW-1:0]  imem_addr,
    input  core_pkg::word_t     imem_wdata,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    output logic                st_en,
    output core_pkg::addr_t     st_addr,
    output core_pkg::word_t     st_data
);

    // fetch to decode
    core_pkg::addr_t     pcd;
    core_pkg::word_t     ir;
    // decode to execute
    core_pkg::addr_t     pce;
    core_pkg::word_t     ire;
    core_pkg::word_t     imm;
    core_pkg::ctrl_t     ctr;
    core_pkg::ctrl_t     ctrm;
    core_pkg::ctrl_t     ctrw;
    core_pkg::reg_addr_t a_addr;
    core_pkg::reg_addr_t b_addr;
    core_pkg::word_t     a_data;
    core_pkg::word_t     b_data;
    // execute to memory and fetch
    core_pkg::word_t     alu_result;
    core_pkg::word_t     store_data;
    core_pkg::reg_addr_t rd;
    logic                redirect;
    core_pkg::addr_t     redirect_pc;

    fetch_stage #(
        .IMEM_AW (IMEM_AW)
    ) fetch_stage_inst (
        .clk_cpu     (clk_cpu),
        .rstn        (rstn),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pcd         (pcd),
        .ir          (ir)
    );

    decode_stage decode_stage_inst (
        .clk_cpu  (clk_cpu),
        .rstn     (rstn),
        .pcd      (pcd),
        .ir       (ir),
        .redirect (redirect),
        .pce      (pce),
        .ire      (ire),
        .a_addr   (a_addr),
        .b_addr   (b_addr),
        .imm      (imm),
        .ctr      (ctr),
        .ctrm     (ctrm),
        .ctrw     (ctrw)
    );

    reg_file reg_file_inst (
        .clk_cpu (clk_cpu),
        .rstn    (rstn),
        .a_addr  (a_addr),
        .b_addr  (b_addr),
        .a_data  (a_data),
        .b_data  (b_data),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    execute_stage execute_stage_inst (
        .clk_cpu     (clk_cpu),
        .rstn        (rstn),
        .pce         (pce),
        .ire         (ire),
        .imm         (imm),
        .ctr         (ctr),
        .a_data      (a_data),
        .b_data      (b_data),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .rd          (rd),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_access_stage #(
        .DMEM_AW (DMEM_AW)
    ) memory_access_stage_inst (
        .clk_cpu    (clk_cpu),
        .rstn       (rstn),
        .alu_result (alu_result),
        .store_data (store_data),
        .rd         (rd),
        .ctrm       (ctrm),
        .ctrw       (ctrw),
        .st_en      (st_en),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

/* logic/memory_access_stage.sv */
`timescale 1ns/1ps

module memory_access_stage #(
    parameter int DMEM_AW = 8
) (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  core_pkg::word_t     alu_result,
    input  core_pkg::word_t     store_data,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::ctrl_t     ctrm,
    input  core_pkg::ctrl_t     ctrw,
    output logic                st_en,
    output core_pkg::addr_t     st_addr,
    output core_pkg::word_t     st_data,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);

    core_pkg::word_t    dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0] dmem_idx;
    core_pkg::word_t    load_data;

    assign dmem_idx  = alu_result[DMEM_AW+1:2];   // word aligned accesses only
    assign load_data = ctrm[core_pkg::CTRL_MEMREAD] ? dmem[dmem_idx] : '0;

    // store report, same cycle as the write
    assign st_en   = ctrm[core_pkg::CTRL_MEMWRITE];
    assign st_addr = alu_result;
    assign st_data = store_data;

    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2**DMEM_AW; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_en) begin
            dmem[dmem_idx] <= store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            wb_rd   <= '0;
            wb_data <= '0;
        end else begin
            wb_rd   <= rd;
            wb_data <= ctrm[core_pkg::CTRL_MEMTOREG] ? load_data : alu_result;
        end
    end

    // ctrw lines up with the MEM/WB contents
    assign wb_en = ctrw[core_pkg::CTRL_REGWRITE] && (wb_rd != '0);

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  core_pkg::addr_t     pce,
    input  core_pkg::word_t     ire,
    input  core_pkg::word_t     imm,
    input  core_pkg::ctrl_t     ctr,
    input  core_pkg::word_t     a_data,
    input  core_pkg::word_t     b_data,
    output core_pkg::word_t     alu_result,
    output core_pkg::word_t     store_data,
    output core_pkg::reg_addr_t rd,
    output logic                redirect,
    output core_pkg::addr_t     redirect_pc
);

    core_pkg::alu_op_t alu_op;
    core_pkg::word_t   op_a;
    core_pkg::word_t   op_b;
    core_pkg::word_t   alu_out;
    core_pkg::word_t   result;
    logic              is_jal;
    logic              taken;

    assign alu_op = core_pkg::alu_op_t'(ctr[core_pkg::CTRL_ALUOP_LO +: 2]);
    assign is_jal = (ire[6:0] == core_pkg::OP_JAL);

    // auipc adds to the pc instead of rs1
    assign op_a = (ire[6:0] == core_pkg::OP_AUIPC) ? pce : a_data;
    assign op_b = ctr[core_pkg::CTRL_ALUSRC] ? imm : b_data;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_SUB: alu_out = op_a - op_b;
            core_pkg::ALU_SLL: alu_out = op_a << op_b[4:0];
            default:           alu_out = op_a + op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (ire[14:12])
            3'b000:  taken = (a_data == b_data);                  // beq
            3'b001:  taken = (a_data != b_data);                  // bne
            3'b100:  taken = ($signed(a_data) < $signed(b_data));  // blt
            3'b101:  taken = ($signed(a_data) >= $signed(b_data)); // bge
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ctr[core_pkg::CTRL_BRANCH] & (is_jal | taken);
    assign redirect_pc = pce + imm;
    assign result      = is_jal ? (pce + 32'd4) : alu_out;   // link value for jal

    // EX/MEM register
    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            alu_result <= '0;
            store_data <= '0;
            rd         <= '0;
        end else begin
            alu_result <= result;
            store_data <= b_data;
            rd         <= ire[11:7];
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  core_pkg::reg_addr_t a_addr,
    input  core_pkg::reg_addr_t b_addr,
    output core_pkg::word_t     a_data,
    output core_pkg::word_t     b_data,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data
);

    core_pkg::word_t regs [32];
    logic            wr_ok;

    assign wr_ok = wb_en && (wb_rd != '0);   // x0 stays zero

    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write shows through to the readers
    assign a_data = (wr_ok && wb_rd == a_addr) ? wb_data : regs[a_addr];
    assign b_data = (wr_ok && wb_rd == b_addr) ? wb_data : regs[b_addr];

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  core_pkg::addr_t     pcd,
    input  core_pkg::word_t     ir,
    input  logic                redirect,
    output core_pkg::addr_t     pce,
    output core_pkg::word_t     ire,
    output core_pkg::reg_addr_t a_addr,
    output core_pkg::reg_addr_t b_addr,
    output core_pkg::word_t     imm,
    output core_pkg::ctrl_t     ctr,
    output core_pkg::ctrl_t     ctrm,
    output core_pkg::ctrl_t     ctrw
);

    logic [2:0]      funct3;
    core_pkg::word_t i_imm;
    core_pkg::word_t s_imm;
    core_pkg::word_t b_imm;
    core_pkg::word_t j_imm;
    core_pkg::word_t u_imm;
    core_pkg::word_t imm_next;
    core_pkg::ctrl_t ctr_next;

    assign funct3 = ir[14:12];

    // immediate formats, all sign extended except u
    assign i_imm = {{20{ir[31]}}, ir[31:20]};
    assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign b_imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign j_imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
    assign u_imm = {ir[31:12], 12'h000};

    always_comb begin
        ctr_next = '0;      // unknown encodings become bubbles
        imm_next = '0;
        case (ir[6:0])
            core_pkg::OP_IMM: begin
                if (funct3 == 3'b000) begin                 // addi
                    imm_next = i_imm;
                    ctr_next[core_pkg::CTRL_ALUSRC]   = 1'b1;
                    ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
                end else if (funct3 == 3'b001) begin        // slli
                    imm_next = {27'h0, ir[24:20]};
                    ctr_next[core_pkg::CTRL_ALUOP_LO +: 2] = core_pkg::ALU_SLL;
                    ctr_next[core_pkg::CTRL_ALUSRC]   = 1'b1;
                    ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
                end
            end
            core_pkg::OP_LOAD: begin                        // lw
                imm_next = i_imm;
                ctr_next[core_pkg::CTRL_MEMREAD]  = 1'b1;
                ctr_next[core_pkg::CTRL_MEMTOREG] = 1'b1;
                ctr_next[core_pkg::CTRL_ALUSRC]   = 1'b1;
                ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
            end
            core_pkg::OP_STORE: begin                       // sw
                imm_next = s_imm;
                ctr_next[core_pkg::CTRL_MEMWRITE] = 1'b1;
                ctr_next[core_pkg::CTRL_ALUSRC]   = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
                    imm_next = b_imm;
                    ctr_next[core_pkg::CTRL_BRANCH] = 1'b1;
                end
            end
            core_pkg::OP_JAL: begin                         // branch bit plus link write
                imm_next = j_imm;
                ctr_next[core_pkg::CTRL_BRANCH]   = 1'b1;
                ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
            end
            core_pkg::OP_AUIPC: begin
                imm_next = u_imm;
                ctr_next[core_pkg::CTRL_ALUSRC]   = 1'b1;
                ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
            end
            core_pkg::OP_REG: begin
                if (funct3 == 3'b000) begin                 // add or sub by funct7
                    if (ir[30]) begin
                        ctr_next[core_pkg::CTRL_ALUOP_LO +: 2] = core_pkg::ALU_SUB;
                    end
                    ctr_next[core_pkg::CTRL_REGWRITE] = 1'b1;
                end
            end
            default: begin
                ctr_next = '0;
            end
        endcase
    end

    // control delay line, one copy per later stage
    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            ctr  <= '0;
            ctrm <= '0;
            ctrw <= '0;
        end else begin
            ctr  <= redirect ? '0 : ctr_next;   // squash the decode slot
            ctrm <= ctr;
            ctrw <= ctrm;
        end
    end

    always_ff @(posedge clk_cpu) begin
        pce    <= pcd;
        ire    <= redirect ? core_pkg::NOP_WORD : ir;
        a_addr <= ir[19:15];
        b_addr <= ir[24:20];
        imm    <= imm_next;
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_AW = 8
) (
    input  logic                clk_cpu,
    input  logic                rstn,
    input  logic                run,
    input  logic                imem_we,
    input  logic [IMEM_AW-1:0]  imem_addr,   // word address
    input  core_pkg::word_t     imem_wdata,
    input  logic                redirect,
    input  core_pkg::addr_t     redirect_pc,
    output core_pkg::addr_t     pcd,
    output core_pkg::word_t     ir
);

    core_pkg::word_t imem [2**IMEM_AW];
    core_pkg::addr_t pc;

    // program load only while the core is halted
    always_ff @(posedge clk_cpu) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk_cpu or negedge rstn) begin
        if (!rstn) begin
            pc  <= '0;
            pcd <= '0;
            ir  <= core_pkg::NOP_WORD;
        end else if (!run) begin
            pc  <= '0;                     // hold at reset vector
            pcd <= '0;
            ir  <= core_pkg::NOP_WORD;
        end else if (redirect) begin
            // word fetched this cycle is on the wrong path
            pc  <= redirect_pc;
            pcd <= pc;
            ir  <= core_pkg::NOP_WORD;
        end else begin
            pc  <= pc + 32'd4;
            pcd <= pc;
            ir  <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

/* logic/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;     // data, immediate or instruction
    typedef logic [31:0] addr_t;     // byte address or pc
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  ctrl_t;     // packed control word

    // bit positions inside ctrl_t
    localparam int CTRL_BRANCH   = 0;
    localparam int CTRL_MEMREAD  = 1;
    localparam int CTRL_MEMTOREG = 2;
    localparam int CTRL_ALUOP_LO = 3;  // two bits wide
    localparam int CTRL_MEMWRITE = 5;
    localparam int CTRL_ALUSRC   = 6;
    localparam int CTRL_REGWRITE = 7;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_SLL = 2'b10
    } alu_op_t;

    // rv32i major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam word_t NOP_WORD = 32'h0000_0013;  // addi x0,x0,0

endpackage
